// File: Makefile
# Verilator build and run of the SPI control plane testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_ctrl
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

# build, run, and fail unless the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/ctrl_reg_bank.sv
/*
  control register bank
  four 4 bit registers updated by set/clear/toggle writes, the soft reset
  and power-up commands, and the read-back mux toward the receiver
*/

`default_nettype none

module ctrl_reg_bank
  import spi_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [addr_bits-1:0] rd_addr,
  input  logic                 rd_addr_valid,
  input  logic [addr_bits-1:0] wr_addr,
  input  logic [addr_bits-1:0] wr_data,
  input  logic                 wr_strobe,
  output logic [ctl_bits-1:0]  rd_data,
  output logic [ctl_bits-1:0]  led,
  output logic [ctl_bits-1:0]  spi_mux,
  output logic [ctl_bits-1:0]  dac_ctl,
  output logic [ctl_bits-1:0]  adc_ctl
);

  ////////////////////////////////////////////////////////////////////////////
  // set/clear/toggle rule

  // overlapping set and clear bits toggle, the rest of the byte is dropped
  function automatic logic [ctl_bits-1:0] update_reg(
    input logic [ctl_bits-1:0] cur,
    input logic [ctl_bits-1:0] set_bits,
    input logic [ctl_bits-1:0] clr_bits
  );
    logic [ctl_bits-1:0] overlap;
    overlap = set_bits & clr_bits;
    if (overlap != '0)
      update_reg = cur ^ overlap;
    else
      update_reg = (cur | set_bits) & ~clr_bits;
  endfunction

  // low nibble sets, high nibble clears
  logic [ctl_bits-1:0] set_bits;
  logic [ctl_bits-1:0] clr_bits;
  reg_addr_t           wr_cmd;
  reg_addr_t           rd_sel;

  assign set_bits = wr_data[ctl_bits-1:0];
  assign clr_bits = wr_data[2*ctl_bits-1:ctl_bits];
  assign wr_cmd   = reg_addr_t'(wr_addr);
  assign rd_sel   = reg_addr_t'(rd_addr);

  ////////////////////////////////////////////////////////////////////////////
  // register update

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      led     <= '0;
      spi_mux <= '0;
      dac_ctl <= dac_reset_value;
      adc_ctl <= '0;
    end
    else if (wr_strobe)
    begin
      case (wr_cmd)
        addr_led:
          led <= update_reg(led, set_bits, clr_bits);
        addr_spi_mux:
          spi_mux <= update_reg(spi_mux, set_bits, clr_bits);
        addr_dac:
          dac_ctl <= update_reg(dac_ctl, set_bits, clr_bits);
        addr_adc:
          adc_ctl <= update_reg(adc_ctl, set_bits, clr_bits);
        // everything to zero, dac included
        addr_soft_reset:
        begin
          led     <= '0;
          spi_mux <= '0;
          dac_ctl <= '0;
          adc_ctl <= '0;
        end
        // rails coming up, dac was configured before and stays
        addr_powerup:
        begin
          led     <= '0;
          adc_ctl <= '0;
        end
        default:
        begin
          // unknown address, no effect
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read-back mux

  // sampled once per frame, right after the address byte
  always_ff @(posedge clk)
  begin
    if (rd_addr_valid)
    begin
      case (rd_sel)
        addr_led:     rd_data <= led;
        addr_spi_mux: rd_data <= spi_mux;
        addr_dac:     rd_data <= dac_ctl;
        addr_adc:     rd_data <= adc_ctl;
        default:      rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/periph_spi_route.sv
/*
  peripheral spi routing
  decodes peripheral chip selects from spi_mux under cs2 and picks
  which miso line goes back to the host
*/

`default_nettype none

module periph_spi_route
  import spi_ctrl_pkg::*;
(
  input  logic                cs2,
  input  logic [ctl_bits-1:0] spi_mux,
  input  logic                bank_dout,
  input  logic [ctl_bits-1:0] periph_miso,
  output logic [ctl_bits-1:0] periph_cs,
  output logic                miso
);

  ////////////////////////////////////////////////////////////////////////////
  // chip select and miso mux

  // purely combinational, follows cs2 with no delay
  always_comb
  begin
    if (cs2)
    begin
      // pass-through idle, every peripheral deselected
      periph_cs = '1;
      // host talks to the register bank
      miso      = bank_dout;
    end
    else
    begin
      // one hot or several, active low selects
      periph_cs = ~spi_mux;
      // any selected peripheral driving high
      miso      = |(spi_mux & periph_miso);
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_ctrl_pkg.sv
/*
  spi control plane definitions
  frame geometry, register address map and reset values shared by the
  receiver, the register bank and the top level
*/

`default_nettype none

package spi_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////////
  // frame geometry

  // one host frame, address byte then data byte
  localparam int frame_bits = 16;

  // address byte width, first on the wire
  localparam int addr_bits = 8;

  // control register width, also the width of the set and clear nibbles
  localparam int ctl_bits = 4;

  //////////////////////////////////////////////////////////////////////////
  // address map

  // register addresses plus the two multi register commands
  typedef enum logic [addr_bits-1:0] {
    // zeroes led and adc only, dac keeps its setup
    addr_powerup    = 8'd6,
    addr_led        = 8'd7,
    // peripheral chip select mask for cs2 traffic
    addr_spi_mux    = 8'd8,
    addr_dac        = 8'd9,
    // zeroes every register
    addr_soft_reset = 8'd11,
    addr_adc        = 8'd14
  } reg_addr_t;

  //////////////////////////////////////////////////////////////////////////
  // reset values

  // dac held in reset until the host releases it
  localparam logic [ctl_bits-1:0] dac_reset_value = 4'b1111;

endpackage

`default_nettype wire

// File: hdl/spi_ctrl_top.sv
/*
  spi control plane top
  frame receiver, control register bank and peripheral routing
*/

`default_nettype none

module spi_ctrl_top
  import spi_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                sck,
  input  logic                cs,
  input  logic                cs2,
  input  logic                mosi,
  input  logic [ctl_bits-1:0] periph_miso,
  output logic                miso,
  output logic [ctl_bits-1:0] periph_cs,
  output logic [ctl_bits-1:0] led,
  output logic [ctl_bits-1:0] dac_ctl,
  output logic [ctl_bits-1:0] adc_ctl
);

  ////////////////////////////////////////////////////////////////////////////
  // internal wiring

  // read request and answer
  logic [addr_bits-1:0] rd_addr;
  logic                 rd_addr_valid;
  logic [ctl_bits-1:0]  rd_data;

  // write commit
  logic [addr_bits-1:0] wr_addr;
  logic [addr_bits-1:0] wr_data;
  logic                 wr_strobe;

  // routing
  logic [ctl_bits-1:0]  spi_mux;
  logic                 bank_dout;

  ////////////////////////////////////////////////////////////////////////////
  // blocks

  spi_frame_rx i_spi_frame_rx (
    .clk           (clk),
    .reset         (reset),
    .sck           (sck),
    .cs            (cs),
    .mosi          (mosi),
    .rd_data       (rd_data),
    .rd_addr       (rd_addr),
    .rd_addr_valid (rd_addr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_strobe     (wr_strobe),
    .bank_dout     (bank_dout)
  );

  ctrl_reg_bank i_ctrl_reg_bank (
    .clk           (clk),
    .reset         (reset),
    .rd_addr       (rd_addr),
    .rd_addr_valid (rd_addr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_strobe     (wr_strobe),
    .rd_data       (rd_data),
    .led           (led),
    .spi_mux       (spi_mux),
    .dac_ctl       (dac_ctl),
    .adc_ctl       (adc_ctl)
  );

  // cs2 traffic bypasses the register bank
  periph_spi_route i_periph_spi_route (
    .cs2         (cs2),
    .spi_mux     (spi_mux),
    .bank_dout   (bank_dout),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .miso        (miso)
  );

endmodule

`default_nettype wire

// File: hdl/spi_frame_rx.sv
/*
  spi frame receiver
  samples sck, cs and mosi in the clk domain, shifts in 16 bit frames,
  serves the read byte back on bank_dout and strobes complete writes
*/

`default_nettype none

module spi_frame_rx
  import spi_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 sck,
  input  logic                 cs,
  input  logic                 mosi,
  input  logic [ctl_bits-1:0]  rd_data,
  output logic [addr_bits-1:0] rd_addr,
  output logic                 rd_addr_valid,
  output logic [addr_bits-1:0] wr_addr,
  output logic [addr_bits-1:0] wr_data,
  output logic                 wr_strobe,
  output logic                 bank_dout
);

  ////////////////////////////////////////////////////////////////////////////
  // pin synchronizers

  // two flops per pin, the third sck and cs flop is for edge detection
  logic sck_meta, sck_sync, sck_prev;
  logic cs_meta, cs_sync, cs_prev;
  logic mosi_meta, mosi_sync;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sck_meta <= 1'b0;
      sck_sync <= 1'b0;
      sck_prev <= 1'b0;
      // cs idles high, deasserted
      cs_meta  <= 1'b1;
      cs_sync  <= 1'b1;
      cs_prev  <= 1'b1;
    end
    else
    begin
      sck_meta <= sck;
      sck_sync <= sck_meta;
      sck_prev <= sck_sync;
      cs_meta  <= cs;
      cs_sync  <= cs_meta;
      cs_prev  <= cs_sync;
    end
  end

  // data pin, no reset needed
  always_ff @(posedge clk)
  begin
    mosi_meta <= mosi;
    mosi_sync <= mosi_meta;
  end

  logic sck_rise, sck_fall, cs_fall, cs_rise;

  assign sck_rise = sck_sync & ~sck_prev;
  assign sck_fall = ~sck_sync & sck_prev;
  assign cs_fall  = ~cs_sync & cs_prev;
  assign cs_rise  = cs_sync & ~cs_prev;

  ////////////////////////////////////////////////////////////////////////////
  // input shifter and bit count

  logic [frame_bits-1:0]       shift_in;
  // one spare bit so a 17 bit frame is not mistaken for 16
  logic [$clog2(frame_bits):0] bit_count;
  logic [addr_bits-1:0]        shift_out;
  logic                        load_pending;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_count     <= '0;
      rd_addr_valid <= 1'b0;
      load_pending  <= 1'b0;
      wr_strobe     <= 1'b0;
      bank_dout     <= 1'b0;
      shift_out     <= '0;
    end
    else
    begin
      rd_addr_valid <= 1'b0;
      wr_strobe     <= 1'b0;
      // rd_data is registered by the bank one cycle after the address
      load_pending  <= rd_addr_valid;

      // start of frame
      if (cs_fall)
      begin
        bit_count <= '0;
        shift_out <= '0;
        bank_dout <= 1'b0;
      end
      else if (!cs_sync && sck_rise)
      begin
        // saturate, long frames must not wrap back to 16
        if (bit_count != '1)
          bit_count <= bit_count + 1'b1;
        // eighth bit completes the address byte
        if (bit_count == addr_bits - 1)
          rd_addr_valid <= 1'b1;
      end

      // read byte, zero extended, msb first
      if (load_pending)
        shift_out <= {{(addr_bits-ctl_bits){1'b0}}, rd_data};
      else if (!cs_sync && sck_fall)
      begin
        bank_dout <= shift_out[addr_bits-1];
        shift_out <= {shift_out[addr_bits-2:0], 1'b0};
      end

      // idle line low between frames
      if (cs_sync)
        bank_dout <= 1'b0;

      // commit only exact frames
      if (cs_rise && bit_count == frame_bits)
        wr_strobe <= 1'b1;
    end
  end

  // shifter and write payload carry no reset
  always_ff @(posedge clk)
  begin
    if (!cs_sync && sck_rise)
      shift_in <= {shift_in[frame_bits-2:0], mosi_sync};
    if (cs_rise)
    begin
      wr_addr <= shift_in[frame_bits-1:addr_bits];
      wr_data <= shift_in[addr_bits-1:0];
    end
  end

  // address byte sits in the low bits once eight bits are in
  assign rd_addr = shift_in[addr_bits-1:0];

endmodule

`default_nettype wire

// File: list.f
hdl/spi_ctrl_pkg.sv
hdl/spi_frame_rx.sv
hdl/ctrl_reg_bank.sv
hdl/periph_spi_route.sv
hdl/spi_ctrl_top.sv
verif/tb_spi_ctrl.sv

// File: verif/tb_spi_ctrl.sv
/*
  spi control plane testbench
  table driven frames against a register model, read-back and
  peripheral routing checks, followed by seeded random write rows
*/

`default_nettype none

module tb_spi_ctrl
  import spi_ctrl_pkg::*;
;

  // one stimulus row
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
    logic [4:0] nbits;
    logic       cs2_level;
    logic [3:0] pmiso;
    logic       check;
  } row_t;

  logic       clk;
  logic       reset;
  logic       sck;
  logic       cs;
  logic       cs2;
  logic       mosi;
  logic [3:0] periph_miso;
  logic       miso;
  logic [3:0] periph_cs;
  logic [3:0] led;
  logic [3:0] dac_ctl;
  logic [3:0] adc_ctl;

  // reference copies of the four registers
  logic [3:0] m_led;
  logic [3:0] m_mux;
  logic [3:0] m_dac;
  logic [3:0] m_adc;

  row_t   rows[$];
  logic   table_ready;
  integer seed;
  int     error_count;

  spi_ctrl_top i_spi_ctrl_top (
    .clk         (clk),
    .reset       (reset),
    .sck         (sck),
    .cs          (cs),
    .cs2         (cs2),
    .mosi        (mosi),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs   (periph_cs),
    .led         (led),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl)
  );

  // period 4
  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  // inputs change 1 unit after the rising edge
  task automatic next_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] exp,
                                 input logic [7:0] act);
    $display("mismatch at time %0t: %s expected %h actual %h", $time, name, exp, act);
    error_count++;
  endtask

  task automatic add_row(input logic [7:0] addr, input logic [7:0] data,
                         input logic [4:0] nbits, input logic cs2_level,
                         input logic [3:0] pmiso, input logic check);
    row_t r;
    r.addr      = addr;
    r.data      = data;
    r.nbits     = nbits;
    r.cs2_level = cs2_level;
    r.pmiso     = pmiso;
    r.check     = check;
    rows.push_back(r);
  endtask

  // model of one register write, bit by bit
  function automatic logic [3:0] model_write(input logic [3:0] cur, input logic [7:0] data);
    logic [3:0] set_mask;
    logic [3:0] clr_mask;
    logic [3:0] both;
    logic [3:0] next;
    set_mask = data[3:0];
    clr_mask = data[7:4];
    both     = set_mask & clr_mask;
    next     = cur;
    for (int b = 0; b < 4; b++)
    begin
      // any overlap, only overlapping bits flip
      if (both != 4'h0)
      begin
        if (both[b])
          next[b] = ~cur[b];
      end
      else if (clr_mask[b])
        next[b] = 1'b0;
      else if (set_mask[b])
        next[b] = 1'b1;
    end
    return next;
  endfunction

  task automatic apply_to_model(input logic [7:0] addr, input logic [7:0] data);
    case (addr)
      addr_led:     m_led = model_write(m_led, data);
      addr_spi_mux: m_mux = model_write(m_mux, data);
      addr_dac:     m_dac = model_write(m_dac, data);
      addr_adc:     m_adc = model_write(m_adc, data);
      addr_soft_reset:
      begin
        m_led = 4'h0;
        m_mux = 4'h0;
        m_dac = 4'h0;
        m_adc = 4'h0;
      end
      // dac and mux survive power-up
      addr_powerup:
      begin
        m_led = 4'h0;
        m_adc = 4'h0;
      end
      default:
      begin
      end
    endcase
  endtask

  function automatic logic [3:0] expected_read(input logic [7:0] addr);
    case (addr)
      addr_led:     return m_led;
      addr_spi_mux: return m_mux;
      addr_dac:     return m_dac;
      addr_adc:     return m_adc;
      default:      return 4'h0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // spi host

  // 5 cycle half periods, msb first, bits past 16 are zeros
  task automatic run_frame(input logic [7:0] addr, input logic [7:0] data,
                           input int nbits, output logic [7:0] rd_byte);
    logic [15:0] word;
    word    = {addr, data};
    rd_byte = 8'h00;
    cs      = 1'b0;
    repeat (5) next_edge();
    for (int i = 0; i < nbits; i++)
    begin
      mosi = (i < frame_bits) ? word[frame_bits-1-i] : 1'b0;
      repeat (5) next_edge();
      sck = 1'b1;
      // bits 9 to 16 carry the read byte
      if (i >= 8 && i < frame_bits)
        rd_byte = {rd_byte[6:0], miso};
      repeat (5) next_edge();
      sck = 1'b0;
    end
    repeat (5) next_edge();
    cs   = 1'b1;
    mosi = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    logic [7:0] rd_byte;
    logic [3:0] exp_rd;
    logic [3:0] exp_cs;
    logic       exp_miso;
    // read sees the register before this frame's write
    exp_rd = expected_read(r.addr);
    run_frame(r.addr, r.data, int'(r.nbits), rd_byte);
    if (int'(r.nbits) == frame_bits)
      apply_to_model(r.addr, r.data);
    // commit settles well inside 10 cycles
    repeat (10) next_edge();
    if (r.check && rd_byte !== {4'h0, exp_rd})
      report_mismatch("read byte", {4'h0, exp_rd}, rd_byte);
    if (led !== m_led)
      report_mismatch("led", m_led, led);
    if (dac_ctl !== m_dac)
      report_mismatch("dac_ctl", m_dac, dac_ctl);
    if (adc_ctl !== m_adc)
      report_mismatch("adc_ctl", m_adc, adc_ctl);

    // routing phase
    cs2         = r.cs2_level;
    periph_miso = r.pmiso;
    next_edge();
    if (!r.cs2_level)
    begin
      exp_cs   = ~m_mux;
      // high when any selected peripheral drives high
      exp_miso = 1'b0;
      for (int b = 0; b < 4; b++)
        if (m_mux[b] && r.pmiso[b])
          exp_miso = 1'b1;
    end
    else
    begin
      // bank idle between frames
      exp_cs   = 4'hf;
      exp_miso = 1'b0;
    end
    if (periph_cs !== exp_cs)
      report_mismatch("periph_cs", exp_cs, periph_cs);
    if (miso !== exp_miso)
      report_mismatch("miso", exp_miso, miso);
    cs2         = 1'b1;
    periph_miso = 4'h0;
    next_edge();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table

  task automatic build_table();
    logic [7:0] valid_addrs[7];
    logic [7:0] pick;
    valid_addrs = '{8'd6, 8'd7, 8'd8, 8'd9, 8'd11, 8'd14, 8'h05};
    // led set, clear, toggle
    add_row(8'd7, 8'h00, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd7, 8'h05, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd7, 8'h10, 16, 1'b1, 4'h0, 1'b1);
    // set bit 0 and clear bit 2 would both show if not dropped
    add_row(8'd7, 8'h63, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd7, 8'h00, 16, 1'b1, 4'h0, 1'b1);
    // dac from its all ones reset
    add_row(8'd9, 8'ha0, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd9, 8'h02, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd9, 8'h55, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd14, 8'h0f, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd14, 8'h30, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd14, 8'hcc, 16, 1'b1, 4'h0, 1'b1);
    // spi_mux and the pass-through
    add_row(8'd8, 8'h05, 16, 1'b0, 4'h4, 1'b1);
    add_row(8'd8, 8'h00, 16, 1'b0, 4'ha, 1'b1);
    add_row(8'd8, 8'h99, 16, 1'b0, 4'h8, 1'b1);
    // unknown addresses
    add_row(8'd3, 8'hff, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'hff, 8'h0f, 16, 1'b1, 4'h0, 1'b1);
    // long and short frames dropped
    // misaligned words would land on adc and led
    add_row(8'd7, 8'h0f, 17, 1'b1, 4'h0, 1'b0);
    add_row(8'd14, 8'h0f, 15, 1'b1, 4'h0, 1'b0);
    // commands
    add_row(8'd14, 8'h03, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd6, 8'h00, 16, 1'b0, 4'hf, 1'b1);
    add_row(8'd9, 8'h00, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd11, 8'h00, 16, 1'b0, 4'hf, 1'b1);
    add_row(8'd9, 8'h00, 16, 1'b1, 4'h0, 1'b1);
    add_row(8'd14, 8'h00, 16, 1'b1, 4'h0, 1'b1);
    // random writes, one invalid address in the draw
    for (int i = 0; i < 40; i++)
    begin
      pick = valid_addrs[$unsigned($random(seed)) % 7];
      add_row(pick, 8'($random(seed)), 16, 1'($random(seed)), 4'($random(seed)), 1'b1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial
  begin
    clk         = 1'b0;
    reset       = 1'b1;
    sck         = 1'b0;
    cs          = 1'b1;
    cs2         = 1'b1;
    mosi        = 1'b0;
    periph_miso = 4'h0;
    table_ready = 1'b0;
    seed        = 32'hcec6;
    error_count = 0;
    m_led       = 4'h0;
    m_mux       = 4'h0;
    m_dac       = dac_reset_value;
    m_adc       = 4'h0;
    build_table();
    table_ready = 1'b1;

    repeat (4) next_edge();
    reset = 1'b0;
    next_edge();
    // reset values
    if (led !== 4'h0)
      report_mismatch("led", 4'h0, led);
    if (adc_ctl !== 4'h0)
      report_mismatch("adc_ctl", 4'h0, adc_ctl);
    if (dac_ctl !== dac_reset_value)
      report_mismatch("dac_ctl", dac_reset_value, dac_ctl);
    if (periph_cs !== 4'hf)
      report_mismatch("periph_cs", 4'hf, periph_cs);

    foreach (rows[i])
      run_row(rows[i]);

    $display("rows run: %0d, errors: %0d", rows.size(), error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    wait (table_ready);
    // rows x 20 x 16 x 10 clk periods
    repeat (rows.size() * 20 * 16 * 10) @(posedge clk);
    $display("timeout: test sequence did not complete, errors so far: %0d", error_count);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
